/* verilog/mem_pkg.sv */
package mem_pkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int BLOCK_WIDTH  = 128;
    localparam int WORD_WIDTH   = 32;

    // data space sits above instruction space.
    localparam logic [ADDR_WIDTH-1:0] DATA_OFFSET = 32'h0000_0800;
    localparam logic [3:0]            DEV_REGION  = 4'h1; // value of addr[19:16].

    localparam int ICACHE_LINES = 8;
    localparam int MEM_BLOCKS   = 256;
    localparam int MEM_LATENCY  = 3; // accept pulse to rvalid.
    localparam int DEV_REGS     = 4;

    // derived widths.
    localparam int OFFSET_BITS    = $clog2(BLOCK_WIDTH / 8);
    localparam int INDEX_BITS     = $clog2(ICACHE_LINES);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int MEM_INDEX_BITS = $clog2(MEM_BLOCKS);
    localparam int LAT_WIDTH      = $clog2(MEM_LATENCY + 1);

    // request side of the block bus.
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  addr;
        logic [BLOCK_WIDTH-1:0] wdata;
        logic                   we;
        logic                   cs;
    } bus_req_t;

    // response side, rvalid is a one cycle pulse.
    typedef struct packed {
        logic [BLOCK_WIDTH-1:0] rdata;
        logic                   rvalid;
    } bus_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_ICACHE = 2'd1,
        ARB_DATA   = 2'd2
    } arb_state_e;

endpackage

/* verilog/block_mem.sv */
`timescale 1ns/1ps

module block_mem import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o,
    output logic     accept_o
);

    logic [BLOCK_WIDTH-1:0]    mem_q [MEM_BLOCKS];
    logic [WORD_WIDTH-1:0]     dev_q [DEV_REGS];
    logic                      busy_q;
    logic [LAT_WIDTH-1:0]      cnt_q;
    logic                      accept_q;
    logic                      rvalid_q;
    logic [BLOCK_WIDTH-1:0]    rdata_q;
    logic [ADDR_WIDTH-1:0]     addr_q;
    logic                      we_q;

    logic                      start;
    logic                      last;
    logic                      req_dev;
    logic                      addr_q_dev;
    logic [MEM_INDEX_BITS-1:0] req_idx;

    assign start      = req_i.cs && !busy_q; // cs is ignored while busy.
    assign last       = busy_q && (cnt_q == LAT_WIDTH'(1));
    assign req_dev    = (req_i.addr[19:16] == DEV_REGION);
    assign addr_q_dev = (addr_q[19:16] == DEV_REGION);
    assign req_idx    = req_i.addr[OFFSET_BITS +: MEM_INDEX_BITS];

    initial begin
        for (int i = 0; i < MEM_BLOCKS; i++) begin
            mem_q[i] = '0;
        end
    end

    always @(posedge clk_i) begin
        if (start && req_i.we && !req_dev) begin
            mem_q[req_idx] <= req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEV_REGS; i++) begin
                dev_q[i] <= '0;
            end
        end else if (start && req_i.we && req_dev) begin
            dev_q[req_i.addr[3:2]] <= req_i.wdata[WORD_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            cnt_q    <= '0;
            accept_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            accept_q <= start;
            rvalid_q <= last;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= LAT_WIDTH'(MEM_LATENCY);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q <= req_i.addr;
            we_q   <= req_i.we;
        end
        if (last) begin
            if (we_q) begin
                rdata_q <= '0; // writes answer with an empty block.
            end else if (addr_q_dev) begin
                rdata_q <= BLOCK_WIDTH'(dev_q[addr_q[3:2]]);
            end else begin
                rdata_q <= mem_q[addr_q[OFFSET_BITS +: MEM_INDEX_BITS]];
            end
        end
    end

    assign rsp_o    = '{rdata: rdata_q, rvalid: rvalid_q};
    assign accept_o = accept_q;

endmodule

/* verilog/icache.sv */
`timescale 1ns/1ps

module icache import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
    input  logic                  fetch_req_i,
    output logic [WORD_WIDTH-1:0] fetch_instr_o,
    output logic                  fetch_valid_o,
    output logic [ADDR_WIDTH-1:0] miss_addr_o,
    output logic                  miss_cs_o,
    input  bus_rsp_t              refill_i
);

    typedef enum logic {
        IC_LOOKUP = 1'b0,
        IC_REFILL = 1'b1
    } ic_state_e;

    ic_state_e              state_q;
    logic [ICACHE_LINES-1:0] valid_q;
    logic [TAG_WIDTH-1:0]   tag_q [ICACHE_LINES];
    logic [BLOCK_WIDTH-1:0] data_q [ICACHE_LINES];
    logic                   miss_cs_q;
    logic                   fetch_valid_q;
    logic [WORD_WIDTH-1:0]  instr_q;

    logic [INDEX_BITS-1:0]  idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic [1:0]             word_sel;
    logic                   hit;
    logic                   lookup;
    logic                   refill_done;

    assign idx      = fetch_addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag      = fetch_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign word_sel = fetch_addr_i[3:2];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);

    // the held request is not looked up again while it is being answered.
    assign lookup      = fetch_req_i && !fetch_valid_q && (state_q == IC_LOOKUP);
    assign refill_done = (state_q == IC_REFILL) && refill_i.rvalid;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q       <= IC_LOOKUP;
            valid_q       <= '0;
            miss_cs_q     <= 1'b0;
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= 1'b0;
            case (state_q)
                IC_LOOKUP: begin
                    if (lookup && hit) begin
                        fetch_valid_q <= 1'b1;
                    end else if (lookup) begin
                        state_q   <= IC_REFILL;
                        miss_cs_q <= 1'b1;
                    end
                end
                IC_REFILL: begin
                    if (refill_done) begin
                        state_q       <= IC_LOOKUP;
                        miss_cs_q     <= 1'b0; // low in the cycle after rvalid.
                        fetch_valid_q <= 1'b1;
                        valid_q[idx]  <= 1'b1;
                    end
                end
                default: state_q <= IC_LOOKUP;
            endcase
        end
    end

    // line data and tags, qualified by valid_q.
    always_ff @(posedge clk_i) begin
        if (lookup && hit) begin
            instr_q <= data_q[idx][word_sel*WORD_WIDTH +: WORD_WIDTH];
        end
        if (refill_done) begin
            data_q[idx] <= refill_i.rdata;
            tag_q[idx]  <= tag;
            instr_q     <= refill_i.rdata[word_sel*WORD_WIDTH +: WORD_WIDTH]; // bypass.
        end
    end

    assign miss_addr_o   = {fetch_addr_i[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign miss_cs_o     = miss_cs_q;
    assign fetch_instr_o = instr_q;
    assign fetch_valid_o = fetch_valid_q;

endmodule

/* verilog/arbiter.sv */
`timescale 1ns/1ps

module arbiter import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // instruction cache side.
    input  logic [ADDR_WIDTH-1:0] i_addr_i,
    input  logic                  i_cs_i,
    output bus_rsp_t              i_rsp_o,
    // data port side.
    input  bus_req_t              d_req_i,
    output bus_rsp_t              d_rsp_o,
    // shared memory bus.
    output bus_req_t              mem_req_o,
    input  bus_rsp_t              mem_rsp_i,
    input  logic                  mem_accept_i
);

    arb_state_e            state_q;
    arb_state_e            state_d;
    logic                  accepted_q;
    logic                  d_is_dev;
    logic [ADDR_WIDTH-1:0] i_addr_blk;
    logic [ADDR_WIDTH-1:0] d_addr_map;

    // icache wins a tie from idle.
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (i_cs_i) begin
                    state_d = ARB_ICACHE;
                end else if (d_req_i.cs) begin
                    state_d = ARB_DATA;
                end
            end
            ARB_ICACHE: begin
                if (!i_cs_i) begin
                    state_d = d_req_i.cs ? ARB_DATA : ARB_IDLE;
                end
            end
            ARB_DATA: begin
                if (!d_req_i.cs) begin
                    state_d = i_cs_i ? ARB_ICACHE : ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    assign i_addr_blk = {i_addr_i[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign d_is_dev   = (d_req_i.addr[19:16] == DEV_REGION);

    // device addresses go through untouched.
    assign d_addr_map = d_is_dev ? d_req_i.addr :
        {d_req_i.addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}} + DATA_OFFSET;

    always_comb begin
        mem_req_o = '0;
        i_rsp_o   = '0;
        d_rsp_o   = '0;
        case (state_q)
            ARB_ICACHE: begin
                mem_req_o.addr = i_addr_blk;
                mem_req_o.cs   = !accepted_q;
                i_rsp_o        = mem_rsp_i;
            end
            ARB_DATA: begin
                mem_req_o.addr  = d_addr_map;
                mem_req_o.wdata = d_req_i.wdata;
                mem_req_o.we    = d_req_i.we;
                mem_req_o.cs    = !accepted_q; // one request per grant.
                d_rsp_o         = mem_rsp_i;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q    <= ARB_IDLE;
            accepted_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // a new owner always starts with a fresh request.
            if (state_d != state_q) begin
                accepted_q <= 1'b0;
            end else if (mem_accept_i) begin
                accepted_q <= 1'b1;
            end
        end
    end

endmodule

/* verilog/mem_subsys.sv */
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
    input  logic                  fetch_req_i,
    output logic [WORD_WIDTH-1:0] fetch_instr_o,
    output logic                  fetch_valid_o,
    input  bus_req_t              d_req_i,
    output bus_rsp_t              d_rsp_o
);

    logic [ADDR_WIDTH-1:0] miss_addr;
    logic                  miss_cs;
    bus_rsp_t              refill_rsp;
    bus_req_t              mem_req;
    bus_rsp_t              mem_rsp;
    logic                  mem_accept;

    icache icache_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_instr_o (fetch_instr_o),
        .fetch_valid_o (fetch_valid_o),
        .miss_addr_o   (miss_addr),
        .miss_cs_o     (miss_cs),
        .refill_i      (refill_rsp)
    );

    arbiter arbiter_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .i_addr_i     (miss_addr),
        .i_cs_i       (miss_cs),
        .i_rsp_o      (refill_rsp),
        .d_req_i      (d_req_i),
        .d_rsp_o      (d_rsp_o),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp),
        .mem_accept_i (mem_accept)
    );

    block_mem block_mem_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp),
        .accept_o (mem_accept)
    );

endmodule

/* bench/mem_subsys_assertions.sv */
`timescale 1ns/1ps

module mem_subsys_assertions import mem_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input arb_state_e state_i,
    input logic       i_cs_i,
    input bus_req_t   d_req_i,
    input bus_req_t   bus_req_i,
    input bus_rsp_t   bus_rsp_i,
    input bus_rsp_t   i_rsp_i,
    input bus_rsp_t   d_rsp_i,
    input logic       mem_accept_i
);

    int failures = 0;

    // bus cs only for a granted owner that still holds its own cs.
    cs_only_with_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_req_i.cs |-> (((state_i == ARB_ICACHE) && i_cs_i) ||
                          ((state_i == ARB_DATA) && d_req_i.cs)))
        else begin
            failures++;
            $error("bus cs high without a granted client that holds cs");
        end

    // each memory rvalid reaches exactly one client.
    one_rvalid_route: assert property (@(posedge clk_i) disable iff (!rst_ni)
        bus_rsp_i.rvalid |-> (i_rsp_i.rvalid != d_rsp_i.rvalid))
        else begin
            failures++;
            $error("rvalid not routed to exactly one client");
        end

    // the accepted request is not repeated.
    cs_drops_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_accept_i |=> !bus_req_i.cs)
        else begin
            failures++;
            $error("bus cs still high in the cycle after mem_accept");
        end

endmodule

/* bench/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb import mem_pkg::*; ();

    localparam int N_DATA   = 24;
    localparam int N_DEV    = 12;
    localparam int N_OFFSET = 12;
    localparam int N_HIT    = 4;
    localparam int N_MIX    = 16;
    // an access may wait behind one access of the other client.
    localparam int ACCESS_CYCLES = 2 * (MEM_LATENCY + 8);
    localparam int ACCESSES = 2 * N_DATA + 3 * N_DEV + 2 * N_OFFSET + 4 * N_HIT + 2 * N_MIX;
    localparam int WATCHDOG_NS = (ACCESSES * ACCESS_CYCLES + 20) * 10;

    logic                  clk;
    logic                  rst_n;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic                  fetch_req;
    logic [WORD_WIDTH-1:0] fetch_instr;
    logic                  fetch_valid;
    bus_req_t              d_req;
    bus_rsp_t              d_rsp;

    logic [31:0]            lfsr;
    int                     checks;
    int                     errors;
    int                     failed_tests;
    logic [BLOCK_WIDTH-1:0] model_mem [MEM_BLOCKS];
    logic [WORD_WIDTH-1:0]  model_dev [DEV_REGS];
    logic                   ic_valid [ICACHE_LINES];
    logic [ADDR_WIDTH-1:7]  ic_tag [ICACHE_LINES]; // above index bits 6:4.
    logic [BLOCK_WIDTH-1:0] ic_line [ICACHE_LINES];

    mem_subsys mem_subsys_inst (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .fetch_addr_i  (fetch_addr),
        .fetch_req_i   (fetch_req),
        .fetch_instr_o (fetch_instr),
        .fetch_valid_o (fetch_valid),
        .d_req_i       (d_req),
        .d_rsp_o       (d_rsp)
    );

    bind arbiter mem_subsys_assertions arbiter_checks (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .state_i      (state_q),
        .i_cs_i       (i_cs_i),
        .d_req_i      (d_req_i),
        .bus_req_i    (mem_req_o),
        .bus_rsp_i    (mem_rsp_i),
        .i_rsp_i      (i_rsp_o),
        .d_rsp_i      (d_rsp_o),
        .mem_accept_i (mem_accept_i)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit.
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [BLOCK_WIDTH-1:0] rand_block();
        logic [BLOCK_WIDTH-1:0] b;
        for (int i = 0; i < 4; i++) begin
            b[i*32 +: 32] = rand_bits(32);
        end
        return b;
    endfunction

    // data blocks sit DATA_OFFSET above the aligned address.
    function automatic int data_index(input logic [31:0] a);
        logic [31:0] mapped;
        mapped = {a[31:4], 4'h0} + DATA_OFFSET;
        return int'(mapped[11:4]);
    endfunction

    task automatic check(input string name, input logic [BLOCK_WIDTH-1:0] expected,
                         input logic [BLOCK_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic data_access(input logic [31:0] addr, input logic we,
                               input logic [BLOCK_WIDTH-1:0] wdata);
        logic [BLOCK_WIDTH-1:0] expected;
        logic                   dev;
        dev = (addr[19:16] == DEV_REGION);
        if (we) begin
            expected = '0; // writes answer with an empty block.
        end else if (dev) begin
            expected = BLOCK_WIDTH'(model_dev[addr[3:2]]);
        end else begin
            expected = model_mem[data_index(addr)];
        end
        d_req = '{addr: addr, wdata: wdata, we: we, cs: 1'b1};
        do begin
            @(posedge clk);
            #1;
        end while (!d_rsp.rvalid);
        check("d_rsp_o.rdata", expected, d_rsp.rdata);
        if (we && dev) begin
            model_dev[addr[3:2]] = wdata[WORD_WIDTH-1:0];
        end else if (we) begin
            model_mem[data_index(addr)] = wdata;
        end
        @(posedge clk);
        #1;
        d_req.cs = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(input logic [31:0] addr);
        int                     idx;
        int                     cycles;
        logic                   hit;
        logic [BLOCK_WIDTH-1:0] line;
        idx  = int'(addr[6:4]);
        hit  = ic_valid[idx] && (ic_tag[idx] == addr[31:7]);
        line = hit ? ic_line[idx] : model_mem[addr[11:4]];
        fetch_addr = addr;
        fetch_req  = 1'b1;
        cycles     = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!fetch_valid);
        check("fetch_instr_o", BLOCK_WIDTH'(line[addr[3:2]*32 +: 32]), BLOCK_WIDTH'(fetch_instr));
        if (hit) begin
            check("fetch_valid_o latency", BLOCK_WIDTH'(1), BLOCK_WIDTH'(cycles));
        end
        ic_valid[idx] = 1'b1;
        ic_tag[idx]   = addr[31:7];
        ic_line[idx]  = line;
        fetch_req = 1'b0;
        @(posedge clk); // the next lookup waits for fetch_valid_o to clear.
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d error(s)", num, name, errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [31:0]            addr;
        logic [31:0]            used [$];
        int                     mark;
        int                     k;
        logic [31:0]            mix_fetch [N_MIX];
        logic [31:0]            mix_addr [N_MIX];
        logic                   mix_we [N_MIX];
        logic [BLOCK_WIDTH-1:0] mix_wdata [N_MIX];
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_addr   = '0;
        fetch_req    = 1'b0;
        d_req        = '0;
        lfsr         = 32'hf1a5_d922;
        checks       = 0;
        errors       = 0;
        failed_tests = 0;
        for (int i = 0; i < MEM_BLOCKS; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < DEV_REGS; i++) begin
            model_dev[i] = '0;
        end
        for (int i = 0; i < ICACHE_LINES; i++) begin
            ic_valid[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        mark = errors;
        for (int i = 0; i < N_DATA; i++) begin
            addr = rand_bits(12);
            used.push_back(addr);
            data_access(addr, 1'b1, rand_block());
        end
        for (int i = 0; i < N_DATA; i++) begin
            k    = int'(rand_bits(5) % used.size());
            addr = (used[k] & 32'hffff_fff0) | rand_bits(4); // low bits are ignored.
            data_access(addr, 1'b0, '0);
        end
        report_test(1, "data writes and reads", mark);

        mark = errors;
        for (int i = 0; i < N_DEV; i++) begin
            addr = 32'h0001_0000 | rand_bits(12);
            data_access(addr, 1'b1, rand_block());
            data_access(32'h0001_0000 | rand_bits(12), 1'b0, '0);
            // the data block that shares the device address bits 11:4.
            data_access({20'h0, addr[11:4] - 8'h80, 4'h0}, 1'b0, '0);
        end
        report_test(2, "device window", mark);

        mark = errors;
        for (int i = 0; i < N_OFFSET; i++) begin
            addr = rand_bits(12);
            data_access(addr, 1'b1, rand_block());
            fetch(addr + DATA_OFFSET);
        end
        report_test(3, "fetch through data offset", mark);

        mark = errors;
        for (int i = 0; i < N_HIT; i++) begin
            addr = 32'h800 | (rand_bits(11) & 32'hffff_fff0);
            for (int j = 0; j < 4; j++) begin
                fetch(addr | (rand_bits(2) << 2));
            end
        end
        report_test(4, "cache hits", mark);

        // fetch blocks 0..63 and data blocks 192..255 never overlap.
        mark = errors;
        for (int i = 0; i < N_MIX; i++) begin
            mix_fetch[i] = rand_bits(10);
            if (rand_bits(2) == 0) begin
                mix_addr[i] = 32'h0001_0000 | rand_bits(4);
            end else begin
                mix_addr[i] = 32'h0000_0400 | rand_bits(10);
            end
            mix_we[i]    = (rand_bits(1) != 0);
            mix_wdata[i] = rand_block();
        end
        fork
            for (int i = 0; i < N_MIX; i++) begin
                fetch(mix_fetch[i]);
            end
            for (int j = 0; j < N_MIX; j++) begin
                data_access(mix_addr[j], mix_we[j], mix_wdata[j]);
            end
        join
        report_test(5, "contention", mark);

        if (mem_subsys_inst.arbiter_inst.arbiter_checks.failures != 0) begin
            $display("bus assertions failed %0d time(s)",
                     mem_subsys_inst.arbiter_inst.arbiter_checks.failures);
            errors += mem_subsys_inst.arbiter_inst.arbiter_checks.failures;
        end
        $display("tests: 5, failed: %0d, checks: %0d, errors: %0d", failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/mem_pkg.sv
verilog/block_mem.sv
verilog/icache.sv
verilog/arbiter.sv
verilog/mem_subsys.sv
bench/mem_subsys_assertions.sv
bench/mem_subsys_tb.sv

/* Makefile */
SIM  = obj_dir/Vmem_subsys_tb
SRCS = $(shell cat project.f)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb -f project.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q "Everything OK" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
